/* Makefile */
# Verilator build and run for the performance monitor testbench

VERILATOR  ?= verilator
TOP        ?= tb_perf_monitor
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
EXTRA_ARGS ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS EXTRA_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST) $(EXTRA_ARGS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+source
source/perf_pkg.sv
source/perf_wr_if.sv
source/perf_event_select.sv
source/perf_counter_bank.sv
source/perf_ctrl_fsm.sv
source/perf_csr_decode.sv
source/perf_monitor.sv
dv/tb_clk_gen.sv
dv/tb_perf_monitor.sv

/* dv/tb_clk_gen.sv */
// Testbench clock and reset source
// 100 ns clock, active low reset held for 8 cycles
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // Half period
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);  // Release away from the active edge
    rst_no = 1'b1;
  end
endmodule

/* dv/tb_perf_monitor.sv */
// Performance monitor testbench
// Directed tests checked against a cycle model of the counters
`include "perf_cfg.svh"

module tb_perf_monitor;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned TIMEOUT_CYCLES = 2000;  // Tests need roughly 320 cycles

  logic                    clk, rst_n, debug_mode, we, err, busy;
  logic                    miss, hit, flushing, amo, imiss;
  logic [`PERF_ADDR_W-1:0] addr;
  logic [`PERF_DATA_W-1:0] wdata, rdata;

  perf_pkg::cnt_t   cnt_m [`PERF_NUM_CNT:1];  // Expected counts
  perf_pkg::event_e sel_m [`PERF_NUM_CNT:1];  // Expected selectors
  logic             prev_flush, prev_amo;     // Levels seen at the last edge
  logic             running;                  // Controller sits in run state
  logic             inhibit_m, sweep;
  integer           seed = 32'h8b3d5c27;
  int unsigned      cycles = 0;

  tb_clk_gen clk_gen (.clk_o(clk), .rst_no(rst_n));

  perf_monitor dut_i (
    .clk_i(clk), .rst_ni(rst_n), .debug_mode_i(debug_mode),
    .addr_i(addr), .we_i(we), .data_i(wdata), .data_o(rdata), .err_o(err), .busy_o(busy),
    .dcache_miss_i(miss), .dcache_hit_i(hit), .dcache_flushing_i(flushing),
    .amo_i(amo), .icache_miss_i(imiss)
  );

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_data(string name, logic [`PERF_DATA_W-1:0] got,
                            logic [`PERF_DATA_W-1:0] expected);
    if (got !== expected) begin
      report_failure($sformatf("error at %0d ns: %s is %h, expected %h",
                               $time, name, got, expected));
    end
  endtask

  task automatic check_bit(string name, logic got, logic expected);
    if (got !== expected) begin
      report_failure($sformatf("error at %0d ns: %s is %b, expected %b",
                               $time, name, got, expected));
    end
  endtask

  task automatic check_event(string name, perf_pkg::event_e got, perf_pkg::event_e expected);
    if (got !== expected) begin
      report_failure($sformatf("error at %0d ns: %s is %s, expected %s",
                               $time, name, got.name(), expected.name()));
    end
  endtask

  // Run away guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  function automatic logic [`PERF_ADDR_W-1:0] cnt_addr(int idx, bit hi);
    if (hi) begin
      return `PERF_ADDR_W'(`PERF_ADDR_CNT_HI_BASE + idx - 1);
    end
    return `PERF_ADDR_W'(`PERF_ADDR_CNT_LO_BASE + idx - 1);
  endfunction

  // Event that a selector code counts in the current cycle
  function automatic logic event_fires(perf_pkg::event_e code);
    case (code)
      perf_pkg::EV_DCACHE_MISS: return miss;
      perf_pkg::EV_DCACHE_HIT:  return hit;
      perf_pkg::EV_FLUSH_CYCLE: return flushing;
      perf_pkg::EV_FLUSH_DONE:  return prev_flush && !flushing;  // Cycle after the fall
      perf_pkg::EV_AMO_DONE:    return prev_amo && !amo;
      perf_pkg::EV_CYCLE:       return 1'b1;
      perf_pkg::EV_ICACHE_MISS: return imiss;
      default:                  return 1'b0;
    endcase
  endfunction

  // Advances one cycle between falling edges and updates the model
  task automatic step();
    logic [`PERF_NUM_CNT:1] inc;
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      inc[i] = running && !debug_mode && event_fires(sel_m[i]);
    end
    @(posedge clk);
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      if (inc[i]) begin
        cnt_m[i] += 1;
      end
    end
    prev_flush = flushing;
    prev_amo   = amo;
    running    = !debug_mode && !inhibit_m && !sweep;  // Next controller state
    @(negedge clk);
  endtask

  task automatic random_events();
    logic [31:0] r;
    r = $random(seed);
    {miss, hit, flushing, amo, imiss} = r[4:0];
  endtask

  task automatic read_csr(logic [`PERF_ADDR_W-1:0] a, output logic [`PERF_DATA_W-1:0] d);
    addr = a;
    #1;  // Read path is combinational
    d = rdata;
  endtask

  task automatic write_csr(logic [`PERF_ADDR_W-1:0] a, logic [`PERF_DATA_W-1:0] d);
    addr  = a;
    wdata = d;
    we    = 1'b1;
    step();
    we    = 1'b0;
  endtask

  task automatic write_ctrl(logic inhibit, logic clear);
    logic [`PERF_DATA_W-1:0] d;
    d = '0;
    d[perf_pkg::CTRL_INHIBIT_BIT] = inhibit;
    d[perf_pkg::CTRL_CLEAR_BIT]   = clear;
    inhibit_m = inhibit;
    sweep     = clear;
    write_csr(`PERF_ADDR_CTRL, d);
  endtask

  task automatic write_sel(int idx, perf_pkg::event_e code);
    write_csr(`PERF_ADDR_W'(`PERF_ADDR_SEL_BASE + idx - 1), `PERF_DATA_W'(code));
    sel_m[idx] = code;  // Old code still counted in the write cycle
  endtask

  // Half write wins over an increment of the same counter
  task automatic write_cnt(int idx, bit hi, logic [`PERF_DATA_W-1:0] val);
    perf_pkg::cnt_t old;
    old = cnt_m[idx];
    write_csr(cnt_addr(idx, hi), val);
    cnt_m[idx] = hi ? {val, old[`PERF_DATA_W-1:0]} : {old[`PERF_CNT_W-1:`PERF_DATA_W], val};
  endtask

  task automatic check_counter(int idx, perf_pkg::cnt_t expected);
    logic [`PERF_DATA_W-1:0] d;
    read_csr(cnt_addr(idx, 1'b0), d);
    check_data($sformatf("cnt%0d_lo", idx), d, expected[`PERF_DATA_W-1:0]);
    read_csr(cnt_addr(idx, 1'b1), d);
    check_data($sformatf("cnt%0d_hi", idx), d, expected[`PERF_CNT_W-1:`PERF_DATA_W]);
  endtask

  task automatic check_model();
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      check_counter(i, cnt_m[i]);
    end
  endtask

  task automatic check_selectors();
    logic [`PERF_DATA_W-1:0] d;
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      read_csr(`PERF_ADDR_W'(`PERF_ADDR_SEL_BASE + i - 1), d);
      check_event($sformatf("sel%0d", i), perf_pkg::event_e'(d[2:0]), sel_m[i]);
    end
  endtask

  task automatic test_reset();
    logic [`PERF_DATA_W-1:0] d;
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      check_counter(i, '0);
    end
    check_selectors();  // Selector i on code i
    read_csr(`PERF_ADDR_CTRL, d);
    check_data("ctrl", d, '0);
    check_bit("busy_o", busy, 1'b0);
    check_bit("err_o", err, 1'b0);
  endtask

  task automatic test_counting();
    perf_pkg::cnt_t before4, before5, before2;
    repeat (200) begin
      random_events();
      step();
    end
    {miss, hit, flushing, amo, imiss} = '0;
    step();
    check_model();
    // Done pulses give one count per falling edge
    before4  = cnt_m[4];
    before5  = cnt_m[5];
    flushing = 1'b1;
    amo      = 1'b1;
    repeat (2) step();
    check_counter(4, before4);
    check_counter(5, before5);
    flushing = 1'b0;
    amo      = 1'b0;
    step();
    check_counter(4, before4 + 1);
    check_counter(5, before5 + 1);
    step();
    check_counter(4, before4 + 1);  // Pulse lasts one cycle only
    check_counter(5, before5 + 1);
    write_sel(2, perf_pkg::EV_CYCLE);
    check_selectors();
    before2 = cnt_m[2];
    repeat (10) step();
    check_counter(2, before2 + 10);
    write_sel(1, perf_pkg::EV_ICACHE_MISS);  // Counter 1 now follows the I-cache
    repeat (20) begin
      random_events();
      step();
    end
    {miss, hit, flushing, amo, imiss} = '0;
    check_model();
  endtask

  task automatic test_rw64();
    write_ctrl(1'b1, 1'b0);  // Counting idle
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      write_cnt(i, 1'b1, $random(seed));
      write_cnt(i, 1'b0, $random(seed));
    end
    check_model();
    write_sel(3, perf_pkg::EV_CYCLE);
    write_cnt(3, 1'b0, 32'hFFFF_FFFF);
    write_cnt(3, 1'b1, 32'h0000_00A5);
    write_ctrl(1'b0, 1'b0);
    step();  // First counted edge carries into hi
    check_counter(3, 64'h0000_00A6_0000_0000);
    check_model();
  endtask

  task automatic test_debug_inhibit();
    perf_pkg::cnt_t          snap [`PERF_NUM_CNT:1];
    logic [`PERF_DATA_W-1:0] d;
    debug_mode = 1'b1;
    snap = cnt_m;
    repeat (8) begin
      random_events();
      step();
    end
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      check_counter(i, snap[i]);
    end
    debug_mode = 1'b0;
    repeat (4) begin
      random_events();
      step();
    end
    check_model();
    write_ctrl(1'b1, 1'b0);
    read_csr(`PERF_ADDR_CTRL, d);
    check_data("ctrl", d, 32'h1);
    snap = cnt_m;
    repeat (8) begin
      random_events();
      step();
    end
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      check_counter(i, snap[i]);
    end
    write_ctrl(1'b0, 1'b0);
    repeat (4) begin
      random_events();
      step();
    end
    check_model();
  endtask

  task automatic test_clear();
    logic [`PERF_DATA_W-1:0] d;
    {miss, hit, flushing, amo, imiss} = '0;
    write_ctrl(1'b0, 1'b1);
    for (int k = 1; k <= `PERF_NUM_CNT; k++) begin
      check_bit("busy_o", busy, 1'b1);
      read_csr(`PERF_ADDR_CTRL, d);
      check_data("ctrl", d, 32'h2);  // Busy bit set and inhibit clear
      if (k == `PERF_NUM_CNT) begin
        sweep = 1'b0;
      end
      if (k == 3) begin
        addr  = cnt_addr(1, 1'b0);  // Counter 1 already swept
        wdata = 32'hDEAD_BEEF;
        we    = 1'b1;
        #1;
        check_bit("err_o", err, 1'b0);
      end
      step();
      we = 1'b0;
      cnt_m[k] = '0;
    end
    check_bit("busy_o", busy, 1'b0);
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      check_counter(i, '0);
    end
  endtask

  task automatic test_unmapped();
    logic [`PERF_ADDR_W-1:0] bad [3];
    logic [`PERF_DATA_W-1:0] d;
    bad = '{12'h322, 12'hB09, 12'h400};  // Just below, just above, far away
    foreach (bad[j]) begin
      addr  = bad[j];
      wdata = '1;
      we    = 1'b1;
      #1;
      check_bit("err_o", err, 1'b1);
      check_data("unmapped read", rdata, '0);
      step();
      we = 1'b0;
      #1;
      check_bit("err_o", err, 1'b0);
    end
    check_model();
    check_selectors();
    read_csr(`PERF_ADDR_CTRL, d);
    check_data("ctrl", d, '0);
  endtask

  initial begin
    {miss, hit, flushing, amo, imiss} = '0;
    debug_mode = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    prev_flush = 1'b0;
    prev_amo   = 1'b0;
    running    = 1'b1;
    inhibit_m  = 1'b0;
    sweep      = 1'b0;
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      cnt_m[i] = '0;
      sel_m[i] = perf_pkg::event_e'(i);
    end
    @(posedge rst_n);  // Released on a falling edge
    test_reset();
    test_counting();
    test_rw64();
    test_debug_inhibit();
    test_clear();
    test_unmapped();
    $display("TEST PASSED");
    $finish;
  end
endmodule

/* source/perf_cfg.svh */
// Cache performance monitor configuration
// Counter geometry and CSR address map
`ifndef PERF_CFG_SVH
`define PERF_CFG_SVH

`define PERF_NUM_CNT 6   // Event counters, numbered 1 to 6
`define PERF_IDX_W   3   // Enough for counter index 1..6
`define PERF_CNT_W   64  // Full counter width
`define PERF_DATA_W  32  // CSR port width, one counter half
`define PERF_ADDR_W  12  // CSR address width

// CSR map, each range holds one entry per counter
`define PERF_ADDR_CTRL        12'h320
`define PERF_ADDR_SEL_BASE    12'h323  // Selectors 1..6
`define PERF_ADDR_CNT_LO_BASE 12'hB03  // Counter low words
`define PERF_ADDR_CNT_HI_BASE 12'hB83  // Counter high words

`endif

/* source/perf_counter_bank.sv */
// Event counter bank
// Six 64-bit counters with sweep clear, half-word writes and event increment
`include "perf_cfg.svh"

module perf_counter_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  perf_wr_if.bank                wr,           // Software writes from decoder
  input  logic [`PERF_NUM_CNT:1] inc_i,        // Selected event per counter
  input  logic                   count_en_i,   // Counting allowed
  input  logic                   clr_en_i,     // Sweep active
  input  perf_pkg::cnt_idx_t     clr_idx_i,    // Counter cleared this cycle
  output perf_pkg::cnt_t         cnt_o [`PERF_NUM_CNT:1]
);

  perf_pkg::cnt_t cnt_q [`PERF_NUM_CNT:1];

  logic [`PERF_NUM_CNT:1] clr_hit;  // Sweep targets counter i
  logic [`PERF_NUM_CNT:1] wr_hit;   // Software write targets counter i

  always_comb begin
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      clr_hit[i] = clr_en_i && (clr_idx_i == i);
      wr_hit[i]  = wr.wr_en && (wr.wr_idx == i);
    end
  end

  // Priority per counter: clear, then write, then count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
        if (clr_hit[i]) begin
          cnt_q[i] <= '0;
        end else if (wr_hit[i]) begin
          // Only the addressed half changes, other half keeps its value
          if (wr.wr_hi) begin
            cnt_q[i][`PERF_CNT_W-1:`PERF_DATA_W] <= wr.wr_data;
          end else begin
            cnt_q[i][`PERF_DATA_W-1:0] <= wr.wr_data;
          end
        end else if (count_en_i && inc_i[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;  // Carries into upper half
        end
      end
    end
  end

  assign cnt_o = cnt_q;

  // Decoder holds off counter writes for the whole sweep
  a_no_wr_during_clr: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    clr_en_i |-> !wr.wr_en
  );

endmodule

/* source/perf_csr_decode.sv */
// CSR decoder
// Maps the strobed CSR port onto control, selector and counter half-word registers
`include "perf_cfg.svh"

module perf_csr_decode (
  input  logic [`PERF_ADDR_W-1:0] addr_i,
  input  logic                    we_i,
  input  logic [`PERF_DATA_W-1:0] data_i,
  output logic [`PERF_DATA_W-1:0] data_o,       // Combinational read data
  output logic                    err_o,        // Write to unmapped address
  perf_wr_if.decoder              wr,           // Counter writes
  output logic                    sel_we_o,
  output perf_pkg::cnt_idx_t      sel_idx_o,
  output perf_pkg::event_e        sel_code_o,
  output logic                    ctrl_we_o,
  output logic                    ctrl_inhibit_o,
  output logic                    ctrl_clear_o,
  input  perf_pkg::cnt_t          cnt_i [`PERF_NUM_CNT:1],
  input  perf_pkg::event_e        sel_i [`PERF_NUM_CNT:1],
  input  perf_pkg::ctrl_state_e   state_i,
  input  logic                    busy_i
);

  logic [`PERF_ADDR_W-1:0] sel_off, lo_off, hi_off;  // Offsets into each range
  logic                    ctrl_hit, sel_hit, lo_hit, hi_hit;
  perf_pkg::cnt_idx_t      sel_idx, lo_idx, hi_idx;

  // Range decode, unsigned wrap puts addresses below base out of range
  assign sel_off  = addr_i - `PERF_ADDR_SEL_BASE;
  assign lo_off   = addr_i - `PERF_ADDR_CNT_LO_BASE;
  assign hi_off   = addr_i - `PERF_ADDR_CNT_HI_BASE;

  assign ctrl_hit = (addr_i == `PERF_ADDR_CTRL);
  assign sel_hit  = (sel_off < `PERF_NUM_CNT);
  assign lo_hit   = (lo_off < `PERF_NUM_CNT);
  assign hi_hit   = (hi_off < `PERF_NUM_CNT);

  // Offset 0 is counter 1
  assign sel_idx  = sel_off[`PERF_IDX_W-1:0] + 1'b1;
  assign lo_idx   = lo_off[`PERF_IDX_W-1:0] + 1'b1;
  assign hi_idx   = hi_off[`PERF_IDX_W-1:0] + 1'b1;

  // Read mux, unmapped reads return zero
  always_comb begin
    data_o = '0;
    if (ctrl_hit) begin
      // Inhibit reads back through the FSM state
      data_o[perf_pkg::CTRL_INHIBIT_BIT] = (state_i == perf_pkg::ST_INHIBIT);
      data_o[perf_pkg::CTRL_CLEAR_BIT]   = busy_i;  // Sweep still running
    end else if (sel_hit) begin
      data_o = `PERF_DATA_W'(sel_i[sel_idx]);
    end else if (lo_hit) begin
      data_o = cnt_i[lo_idx][`PERF_DATA_W-1:0];
    end else if (hi_hit) begin
      data_o = cnt_i[hi_idx][`PERF_CNT_W-1:`PERF_DATA_W];
    end
  end

  // Write with no target is flagged and dropped
  assign err_o = we_i && !(ctrl_hit || sel_hit || lo_hit || hi_hit);

  // Control register
  assign ctrl_we_o      = we_i && ctrl_hit;
  assign ctrl_inhibit_o = data_i[perf_pkg::CTRL_INHIBIT_BIT];
  assign ctrl_clear_o   = data_i[perf_pkg::CTRL_CLEAR_BIT];

  // Selectors, low bits carry the event code
  assign sel_we_o   = we_i && sel_hit;
  assign sel_idx_o  = sel_idx;
  assign sel_code_o = perf_pkg::event_e'(data_i[$bits(perf_pkg::event_e)-1:0]);

  // Counter halves, swallowed while the sweep runs
  assign wr.wr_en   = we_i && (lo_hit || hi_hit) && !busy_i;
  assign wr.wr_idx  = hi_hit ? hi_idx : lo_idx;
  assign wr.wr_hi   = hi_hit;
  assign wr.wr_data = data_i;

endmodule

/* source/perf_ctrl_fsm.sv */
// Counter control FSM
// Run, inhibit, debug halt and a six-cycle clear sweep
`include "perf_cfg.svh"

module perf_ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  debug_mode_i,
  input  logic                  ctrl_we_i,       // Control register write
  input  logic                  ctrl_inhibit_i,  // Inhibit bit of the write
  input  logic                  ctrl_clear_i,    // Clear bit of the write
  output logic                  count_en_o,
  output logic                  clr_en_o,
  output perf_pkg::cnt_idx_t    clr_idx_o,
  output logic                  busy_o,
  output perf_pkg::ctrl_state_e state_o
);

  perf_pkg::ctrl_state_e state_q, state_d, idle_state;
  perf_pkg::cnt_idx_t    clr_idx_q, clr_idx_d;
  logic                  inhibit_q, inhibit_d;

  // Inhibit is sticky, survives a sweep
  assign inhibit_d = ctrl_we_i ? ctrl_inhibit_i : inhibit_q;

  // State outside a sweep, debug wins over inhibit
  assign idle_state = debug_mode_i ? perf_pkg::ST_DEBUG :
                      inhibit_d    ? perf_pkg::ST_INHIBIT : perf_pkg::ST_RUN;

  always_comb begin
    state_d   = idle_state;
    clr_idx_d = clr_idx_q;
    if (state_q == perf_pkg::ST_CLEAR) begin
      if (clr_idx_q == `PERF_IDX_W'(`PERF_NUM_CNT)) begin
        clr_idx_d = `PERF_IDX_W'(1);  // Last counter done, park index
      end else begin
        state_d   = perf_pkg::ST_CLEAR;
        clr_idx_d = clr_idx_q + 1'b1;
      end
    end else if (ctrl_we_i && ctrl_clear_i) begin
      state_d   = perf_pkg::ST_CLEAR;  // Sweep starts next cycle
      clr_idx_d = `PERF_IDX_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= perf_pkg::ST_RUN;
      clr_idx_q <= `PERF_IDX_W'(1);
      inhibit_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      clr_idx_q <= clr_idx_d;
      inhibit_q <= inhibit_d;
    end
  end

  // Debug input also gates directly, so the first debug cycle already holds
  assign count_en_o = (state_q == perf_pkg::ST_RUN) && !debug_mode_i;
  assign clr_en_o   = (state_q == perf_pkg::ST_CLEAR);
  assign busy_o     = clr_en_o;
  assign clr_idx_o  = clr_idx_q;
  assign state_o    = state_q;

  // One cycle per counter, then back out of the sweep
  a_busy_len: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(busy_o) |-> busy_o [*`PERF_NUM_CNT] ##1 !busy_o
  );

endmodule

/* source/perf_event_select.sv */
// Event selection
// Forms the flush/amo done pulses and routes one event per counter via its selector
`include "perf_cfg.svh"

module perf_event_select (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      sel_we_i,     // Selector write strobe
  input  perf_pkg::cnt_idx_t        sel_idx_i,    // Selector to write
  input  perf_pkg::event_e          sel_code_i,   // New event code
  input  logic                      dcache_miss_i,
  input  logic                      dcache_hit_i,
  input  logic                      dcache_flushing_i,
  input  logic                      amo_i,
  input  logic                      icache_miss_i,
  output logic [`PERF_NUM_CNT:1]    inc_o,        // Increment request per counter
  output perf_pkg::event_e          sel_o [`PERF_NUM_CNT:1]
);

  logic flushing_q;  // Previous flushing level
  logic amo_q;       // Previous amo level
  logic flush_done;
  logic amo_done;

  perf_pkg::event_e sel_q [`PERF_NUM_CNT:1];

  // Falling edge detect, high for the cycle after the input drops
  assign flush_done = flushing_q & ~dcache_flushing_i;
  assign amo_done   = amo_q & ~amo_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flushing_q <= 1'b0;
      amo_q      <= 1'b0;
      for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
        sel_q[i] <= perf_pkg::event_e'(i);  // Selector i starts on code i
      end
    end else begin
      flushing_q <= dcache_flushing_i;
      amo_q      <= amo_i;
      for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
        if (sel_we_i && (sel_idx_i == i)) begin
          sel_q[i] <= sel_code_i;
        end
      end
    end
  end

  // One event mux per counter
  always_comb begin
    inc_o = '0;
    for (int i = 1; i <= `PERF_NUM_CNT; i++) begin
      unique case (sel_q[i])
        perf_pkg::EV_NONE:        inc_o[i] = 1'b0;
        perf_pkg::EV_DCACHE_MISS: inc_o[i] = dcache_miss_i;
        perf_pkg::EV_DCACHE_HIT:  inc_o[i] = dcache_hit_i;
        perf_pkg::EV_FLUSH_CYCLE: inc_o[i] = dcache_flushing_i;
        perf_pkg::EV_FLUSH_DONE:  inc_o[i] = flush_done;
        perf_pkg::EV_AMO_DONE:    inc_o[i] = amo_done;
        perf_pkg::EV_CYCLE:       inc_o[i] = 1'b1;
        perf_pkg::EV_ICACHE_MISS: inc_o[i] = icache_miss_i;
      endcase
    end
  end

  assign sel_o = sel_q;  // Read back through the CSR decoder

  // Decoder only strobes selectors inside the mapped range
  a_sel_idx_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    sel_we_i |-> (sel_idx_i >= 1 && sel_idx_i <= `PERF_NUM_CNT)
  );

endmodule

/* source/perf_monitor.sv */
// Cache performance monitor top
// Six selectable 64-bit event counters behind a strobed 32-bit CSR port
`include "perf_cfg.svh"

module perf_monitor (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    debug_mode_i,  // Core halted, counters hold
  input  logic [`PERF_ADDR_W-1:0] addr_i,
  input  logic                    we_i,
  input  logic [`PERF_DATA_W-1:0] data_i,
  output logic [`PERF_DATA_W-1:0] data_o,
  output logic                    err_o,
  output logic                    busy_o,        // Clear sweep running
  input  logic                    dcache_miss_i,
  input  logic                    dcache_hit_i,
  input  logic                    dcache_flushing_i,
  input  logic                    amo_i,
  input  logic                    icache_miss_i
);

  perf_wr_if wr_bus ();  // Decoder to bank writes

  logic                   sel_we;
  perf_pkg::cnt_idx_t     sel_idx;
  perf_pkg::event_e       sel_code;
  perf_pkg::event_e       sel [`PERF_NUM_CNT:1];
  logic                   ctrl_we, ctrl_inhibit, ctrl_clear;
  logic                   count_en, clr_en;
  perf_pkg::cnt_idx_t     clr_idx;
  perf_pkg::ctrl_state_e  state;
  logic [`PERF_NUM_CNT:1] inc;
  perf_pkg::cnt_t         cnt [`PERF_NUM_CNT:1];

  perf_csr_decode i_decode (
    .addr_i, .we_i, .data_i, .data_o, .err_o,
    .wr             (wr_bus),
    .sel_we_o       (sel_we),
    .sel_idx_o      (sel_idx),
    .sel_code_o     (sel_code),
    .ctrl_we_o      (ctrl_we),
    .ctrl_inhibit_o (ctrl_inhibit),
    .ctrl_clear_o   (ctrl_clear),
    .cnt_i          (cnt),
    .sel_i          (sel),
    .state_i        (state),
    .busy_i         (busy_o)
  );

  perf_event_select i_select (
    .clk_i, .rst_ni,
    .sel_we_i   (sel_we),
    .sel_idx_i  (sel_idx),
    .sel_code_i (sel_code),
    .dcache_miss_i, .dcache_hit_i, .dcache_flushing_i, .amo_i, .icache_miss_i,
    .inc_o      (inc),
    .sel_o      (sel)
  );

  perf_ctrl_fsm i_ctrl (
    .clk_i, .rst_ni, .debug_mode_i,
    .ctrl_we_i      (ctrl_we),
    .ctrl_inhibit_i (ctrl_inhibit),
    .ctrl_clear_i   (ctrl_clear),
    .count_en_o     (count_en),
    .clr_en_o       (clr_en),
    .clr_idx_o      (clr_idx),
    .busy_o,
    .state_o        (state)
  );

  perf_counter_bank i_bank (
    .clk_i, .rst_ni,
    .wr         (wr_bus),
    .inc_i      (inc),
    .count_en_i (count_en),
    .clr_en_i   (clr_en),
    .clr_idx_i  (clr_idx),
    .cnt_o      (cnt)
  );

endmodule

/* source/perf_pkg.sv */
// Performance monitor types
// Event codes, control states and counter value type
`include "perf_cfg.svh"

package perf_pkg;

  // Event selector codes, one per selectable source
  typedef enum logic [2:0] {
    EV_NONE        = 3'd0,  // Counter idle
    EV_DCACHE_MISS = 3'd1,
    EV_DCACHE_HIT  = 3'd2,
    EV_FLUSH_CYCLE = 3'd3,  // Every cycle the D-cache flushes
    EV_FLUSH_DONE  = 3'd4,  // Pulse at end of flush
    EV_AMO_DONE    = 3'd5,  // Pulse at end of atomic op
    EV_CYCLE       = 3'd6,  // Free running
    EV_ICACHE_MISS = 3'd7
  } event_e;

  // Control FSM states
  typedef enum logic [1:0] {
    ST_RUN     = 2'd0,  // Counting
    ST_INHIBIT = 2'd1,  // Software inhibit set
    ST_DEBUG   = 2'd2,  // Core halted in debug
    ST_CLEAR   = 2'd3   // Clear sweep in progress
  } ctrl_state_e;

  typedef logic [`PERF_CNT_W-1:0] cnt_t;      // One counter value
  typedef logic [`PERF_IDX_W-1:0] cnt_idx_t;  // Counter index, 1-based

  // Control register bit positions
  localparam int unsigned CTRL_INHIBIT_BIT = 0;  // Sticky inhibit
  localparam int unsigned CTRL_CLEAR_BIT   = 1;  // One-shot clear request

endpackage

/* source/perf_wr_if.sv */
// Counter write bus
// Carries one 32-bit half-word write from the CSR decoder to the counter bank
`include "perf_cfg.svh"

interface perf_wr_if;
  logic                    wr_en;    // Write strobe
  perf_pkg::cnt_idx_t      wr_idx;   // Target counter, 1..6
  logic                    wr_hi;    // Upper half when set
  logic [`PERF_DATA_W-1:0] wr_data;  // Half-word payload

  modport decoder (
    output wr_en, wr_idx, wr_hi, wr_data
  );

  modport bank (
    input  wr_en, wr_idx, wr_hi, wr_data
  );
endinterface
